// File: all.f
verilog/prot_pkg.sv
verilog/pmp_csr.sv
verilog/pma_checker.sv
verilog/pmp_checker.sv
verilog/prot_fault_unit.sv
verilog/prot_unit.sv
testbench/prot_unit_tb.sv

// File: testbench/prot_unit_tb.sv
// Testbench for the memory protection unit
// Drives fetch, data and CSR traffic, keeps a reference model of the
// PMA table and the PMP entries, and checks every output by assertion
module prot_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import prot_pkg::*;

    typedef enum {FETCH, LOAD, STORE} access_kind_t;

    logic                         CLK;
    logic                         rst_n;
    priv_level_t                  priv_level;
    csr_req_t                     csr_req;
    mem_req_t                     ireq;
    mem_req_t                     dreq;
    logic                         dwen;
    logic [31:0]                  csr_rdata;
    logic                         prot_fault_i;
    logic                         prot_fault_l;
    logic                         prot_fault_s;
    logic [3:0]                   fault_cause;
    logic [31:0]                  fault_addr;

    // Reference state and expected outputs
    pmp_cfg_t [PMP_ENTRIES-1:0]   m_cfg;
    logic [PMP_ENTRIES-1:0][31:0] m_addr;
    logic                         exp_i;
    logic                         exp_l;
    logic                         exp_s;
    logic [3:0]                   exp_cause;
    logic [31:0]                  exp_addr;
    logic [31:0]                  exp_rdata;
    int                           cyc = 0;
    string                        test_name = "reset";

    prot_unit dut (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .priv_level   (priv_level),
        .csr_req      (csr_req),
        .ireq         (ireq),
        .dreq         (dreq),
        .dwen         (dwen),
        .csr_rdata    (csr_rdata),
        .prot_fault_i (prot_fault_i),
        .prot_fault_l (prot_fault_l),
        .prot_fault_s (prot_fault_s),
        .fault_cause  (fault_cause),
        .fault_addr   (fault_addr)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Run limit covers about 1100 cycles of stimulus with margin
    always @(posedge CLK) begin
        cyc <= cyc + 1;
        if (cyc == 3000) begin
            $display("Timeout: the run did not finish within 3000 cycles");
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    task automatic report_mismatch(string what, logic [63:0] expected, logic [63:0] actual);
        $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Region table written out as byte ranges
    function automatic logic pma_expect(logic [31:0] a, acc_width_t w, access_kind_t kind);
        logic in_rom;
        logic in_io;
        logic in_ram;

        in_rom = (a >= ROM_BASE) && (a <= ROM_BASE + ROM_SIZE - 32'd1);
        in_io  = (a >= IO_BASE) && (a <= IO_BASE + IO_SIZE - 32'd1) && (w == ACC_WORD);
        in_ram = (a >= RAM_BASE) && (a <= RAM_BASE + RAM_SIZE - 32'd1);
        case (kind)
            FETCH:   return !(in_rom || in_ram);
            LOAD:    return !(in_rom || in_io || in_ram);
            default: return !(in_io || in_ram);
        endcase
    endfunction

    // Each entry becomes a word range [base, top) and the first hit decides
    function automatic logic pmp_expect(priv_level_t priv, logic [31:0] a, access_kind_t kind);
        logic [63:0] w;
        logic [63:0] prev;
        logic [63:0] base;
        logic [63:0] top;
        int          ones;

        w    = {32'h0, a} >> 2;
        prev = '0;
        for (int i = 0; i < PMP_ENTRIES; i++) begin
            base = '0;
            top  = '0;
            case (m_cfg[i].a)
                PMP_TOR: begin
                    base = prev;
                    top  = {32'h0, m_addr[i]};
                end
                PMP_NA4: begin
                    base = {32'h0, m_addr[i]};
                    top  = base + 64'd1;
                end
                PMP_NAPOT: begin
                    ones = 0;
                    while (ones < 32 && m_addr[i][ones]) begin
                        ones++;
                    end
                    top  = 64'd1 << (ones + 1);
                    base = {32'h0, m_addr[i]} & ~(top - 64'd1);
                    top  = base + top;
                end
                default: ;
            endcase
            prev = {32'h0, m_addr[i]};
            if (w >= base && w < top) begin
                if (priv == M_MODE && !m_cfg[i].l) begin
                    return 1'b0;
                end
                case (kind)
                    FETCH:   return !m_cfg[i].x;
                    LOAD:    return !m_cfg[i].r;
                    default: return !m_cfg[i].w;
                endcase
            end
        end
        return priv != M_MODE;
    endfunction

    function automatic logic addr_frozen(int i);
        if (m_cfg[i].l) begin
            return 1'b1;
        end
        if (i < PMP_ENTRIES - 1) begin
            return m_cfg[i+1].l && (m_cfg[i+1].a == PMP_TOR);
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] csr_readback(logic [11:0] a, pmp_cfg_t [PMP_ENTRIES-1:0] cfg,
                                                 logic [PMP_ENTRIES-1:0][31:0] addrs);
        if (a == CSR_PMPCFG0) begin
            return cfg;
        end
        for (int i = 0; i < PMP_ENTRIES; i++) begin
            if (a == CSR_PMPADDR0 + 12'(i)) begin
                return addrs[i];
            end
        end
        return '0;
    endfunction

    // Shadow CSRs with reserved cfg bits 6:5 kept clear
    always @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            m_cfg  <= '0;
            m_addr <= '0;
        end else if (csr_req.wen) begin
            for (int i = 0; i < PMP_ENTRIES; i++) begin
                if (csr_req.addr == CSR_PMPCFG0 && !m_cfg[i].l) begin
                    m_cfg[i] <= pmp_cfg_t'(csr_req.wdata[8*i +: 8] & 8'h9F);
                end
                if (csr_req.addr == CSR_PMPADDR0 + 12'(i) && !addr_frozen(i)) begin
                    m_addr[i] <= csr_req.wdata;
                end
            end
        end
    end

    assign exp_rdata = csr_readback(csr_req.addr, m_cfg, m_addr);

    // Expected strobes one cycle after the request
    always @(posedge CLK or negedge rst_n) begin : model
        logic fi;
        logic fl;
        logic fs;

        fi = ireq.en && (pma_expect(ireq.addr, ireq.width, FETCH) ||
                         pmp_expect(priv_level, ireq.addr, FETCH));
        fl = dreq.en && !dwen && (pma_expect(dreq.addr, dreq.width, LOAD) ||
                                  pmp_expect(priv_level, dreq.addr, LOAD));
        fs = dreq.en && dwen && (pma_expect(dreq.addr, dreq.width, STORE) ||
                                 pmp_expect(priv_level, dreq.addr, STORE));
        if (!rst_n) begin
            {exp_i, exp_l, exp_s} <= 3'b000;
            exp_cause <= 4'd0;
            exp_addr  <= '0;
        end else begin
            exp_i     <= fi;
            exp_l     <= fl;
            exp_s     <= fs;
            exp_cause <= fi ? 4'd1 : fl ? 4'd5 : fs ? 4'd7 : 4'd0;
            exp_addr  <= fi ? ireq.addr : (fl || fs) ? dreq.addr : 32'h0;
        end
    end

    a_reset_state: assert property (@(posedge CLK) (!rst_n && cyc >= 2) |->
        (!prot_fault_i && !prot_fault_l && !prot_fault_s && fault_cause == CAUSE_NONE &&
         csr_rdata == 32'h0))
        else report_mismatch("reset outputs", 64'h0,
            {$sampled({prot_fault_i, prot_fault_l, prot_fault_s}), $sampled(fault_cause),
             $sampled(csr_rdata)});

    a_fault_i: assert property (@(posedge CLK) disable iff (!rst_n) prot_fault_i == exp_i)
        else report_mismatch("prot_fault_i", $sampled(exp_i), $sampled(prot_fault_i));
    a_fault_l: assert property (@(posedge CLK) disable iff (!rst_n) prot_fault_l == exp_l)
        else report_mismatch("prot_fault_l", $sampled(exp_l), $sampled(prot_fault_l));
    a_fault_s: assert property (@(posedge CLK) disable iff (!rst_n) prot_fault_s == exp_s)
        else report_mismatch("prot_fault_s", $sampled(exp_s), $sampled(prot_fault_s));
    a_cause: assert property (@(posedge CLK) disable iff (!rst_n) fault_cause == exp_cause)
        else report_mismatch("fault_cause", $sampled(exp_cause), $sampled(fault_cause));
    a_addr: assert property (@(posedge CLK) disable iff (!rst_n) fault_addr == exp_addr)
        else report_mismatch("fault_addr", $sampled(exp_addr), $sampled(fault_addr));
    a_rdata: assert property (@(posedge CLK) disable iff (!rst_n) csr_rdata == exp_rdata)
        else report_mismatch("csr_rdata", $sampled(exp_rdata), $sampled(csr_rdata));

    // Mostly region interiors plus edges of IO, RAM, the NA4 word and the TOR top
    function automatic logic [31:0] pick_addr();
        logic [31:0] off;

        off = $urandom;
        case ($urandom_range(0, 6))
            0: return ROM_BASE + (off % ROM_SIZE);
            1: return IO_BASE + (off % IO_SIZE);
            2: return RAM_BASE + (off % RAM_SIZE);
            3: return IO_BASE + IO_SIZE - 32'd8 + (off % 32'd16);
            4: return RAM_BASE - 32'd8 + (off % 32'd16);
            5: return ((off[0]) ? 32'h8000_00F8 : 32'h0000_3FF8) + (off % 32'd16);
            default: return off;
        endcase
    endfunction

    function automatic logic [11:0] pick_csr_addr();
        case ($urandom_range(0, 5))
            0: return CSR_PMPCFG0;
            5: return 12'h3B4;
            default: return CSR_PMPADDR0 + 12'($urandom_range(0, 3));
        endcase
    endfunction

    task automatic csr_write(logic [11:0] csr_addr, logic [31:0] data);
        @(posedge CLK);
        ireq    <= '0;
        dreq    <= '0;
        dwen    <= 1'b0;
        csr_req <= '{wen: 1'b1, addr: csr_addr, wdata: data};
        // Read back in the following cycle
        @(posedge CLK);
        csr_req <= '{wen: 1'b0, addr: csr_addr, wdata: 32'h0};
    endtask

    task automatic random_access(priv_level_t priv);
        @(posedge CLK);
        priv_level <= priv;
        ireq       <= '{en: ($urandom_range(0, 3) != 0), addr: pick_addr(),
                        width: acc_width_t'($urandom_range(0, 2))};
        dreq       <= '{en: ($urandom_range(0, 3) != 0), addr: pick_addr(),
                        width: acc_width_t'($urandom_range(0, 2))};
        dwen       <= $urandom_range(0, 1);
        csr_req    <= '{wen: 1'b0, addr: pick_csr_addr(), wdata: $urandom};
    endtask

    task automatic drive_pair(priv_level_t priv, logic [31:0] i_addr, logic [31:0] d_addr,
                              logic store, acc_width_t width);
        @(posedge CLK);
        priv_level <= priv;
        ireq       <= '{en: 1'b1, addr: i_addr, width: ACC_WORD};
        dreq       <= '{en: 1'b1, addr: d_addr, width: width};
        dwen       <= store;
    endtask

    initial begin
        void'($urandom(32'h2a2a));
        rst_n      = 1'b0;
        priv_level = M_MODE;
        csr_req    = '{wen: 1'b0, addr: CSR_PMPCFG0, wdata: 32'h0};
        ireq       = '0;
        dreq       = '0;
        dwen       = 1'b0;
        repeat (16) @(posedge CLK);
        rst_n <= 1'b1;

        test_name = "pma_only";
        repeat (300) random_access(M_MODE);

        // TOR over low ROM, NA4 in RAM, locked NAPOT over low RAM, NAPOT over IO
        test_name = "pmp_match";
        csr_write(CSR_PMPADDR0, 32'h0000_1000);
        csr_write(CSR_PMPADDR0 + 12'd1, 32'h2000_0040);
        csr_write(CSR_PMPADDR0 + 12'd2, 32'h2000_0FFF);
        csr_write(CSR_PMPADDR0 + 12'd3, 32'h1000_01FF);
        csr_write(CSR_PMPCFG0, 32'h1B9B_110D);
        repeat (400) random_access(priv_level_t'($urandom_range(0, 1) ? 2'b11 : 2'b00));

        // Entry 1 becomes a locked TOR top, which also freezes pmpaddr0
        test_name = "locking";
        csr_write(CSR_PMPCFG0, 32'h1B00_890D);
        csr_write(CSR_PMPADDR0, 32'h0000_0000);
        csr_write(CSR_PMPADDR0 + 12'd1, 32'h0000_0000);
        csr_write(CSR_PMPADDR0 + 12'd2, 32'h0000_0000);
        csr_write(CSR_PMPADDR0 + 12'd3, 32'h1000_00FF);
        csr_write(CSR_PMPCFG0, 32'h7F00_0000);
        csr_write(CSR_PMPCFG0, 32'h0000_0000);
        repeat (300) random_access(priv_level_t'($urandom_range(0, 1) ? 2'b11 : 2'b00));

        test_name = "combining";
        drive_pair(U_MODE, 32'h2000_0000, 32'h9000_0000, 1'b0, ACC_WORD);
        drive_pair(U_MODE, 32'h2000_0000, 32'h0000_0100, 1'b1, ACC_WORD);
        drive_pair(M_MODE, 32'h2000_0004, 32'h4000_0002, 1'b1, ACC_HALF);
        drive_pair(M_MODE, 32'h0000_0200, 32'h4000_0002, 1'b0, ACC_HALF);
        drive_pair(M_MODE, 32'h0000_0200, 32'h0000_0300, 1'b1, ACC_BYTE);
        drive_pair(M_MODE, 32'h0000_0200, 32'h8000_4000, 1'b1, ACC_WORD);
        repeat (100) random_access(U_MODE);

        @(posedge CLK);
        ireq <= '0;
        dreq <= '0;
        dwen <= 1'b0;
        repeat (3) @(posedge CLK);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: verilog/pma_checker.sv
// PMA checker
// Looks up fetch, load and store addresses in the fixed region table
// and flags missing permissions, unmapped space and narrow IO accesses
module pma_checker (
    input  prot_pkg::mem_req_t     ireq,
    input  prot_pkg::mem_req_t     dreq,
    input  logic                   dwen,
    output prot_pkg::prot_result_t pma_res
);

    import prot_pkg::*;

    function automatic logic pma_fault(
        input mem_req_t req,
        input logic     need_r,
        input logic     need_w,
        input logic     need_x
    );
        pma_attr_t attr;
        logic      hit;

        attr = '0;
        hit  = 1'b1;
        // Offset compare keeps the range check free of overflow
        if ((req.addr - ROM_BASE) < ROM_SIZE) begin
            attr = ROM_ATTR;
        end else if ((req.addr - IO_BASE) < IO_SIZE) begin
            attr = IO_ATTR;
        end else if ((req.addr - RAM_BASE) < RAM_SIZE) begin
            attr = RAM_ATTR;
        end else begin
            hit = 1'b0;
        end

        if (!hit) begin
            return 1'b1;
        end
        return (need_r & ~attr.r) |
               (need_w & ~attr.w) |
               (need_x & ~attr.x) |
               (attr.word_only & (req.width != ACC_WORD));
    endfunction

    // Disabled ports never fault
    always_comb begin
        pma_res.i_fault = ireq.en && pma_fault(ireq, 1'b0, 1'b0, 1'b1);
        pma_res.l_fault = dreq.en && !dwen && pma_fault(dreq, 1'b1, 1'b0, 1'b0);
        pma_res.s_fault = dreq.en && dwen && pma_fault(dreq, 1'b0, 1'b1, 1'b0);
    end

endmodule

// File: verilog/pmp_checker.sv
// PMP checker
// Matches each request against four programmable entries, lowest
// entry first, and applies its permissions for the current mode
module pmp_checker (
    input  prot_pkg::priv_level_t                          priv_level,
    input  prot_pkg::mem_req_t                             ireq,
    input  prot_pkg::mem_req_t                             dreq,
    input  logic                                           dwen,
    input  prot_pkg::pmp_cfg_t [prot_pkg::PMP_ENTRIES-1:0] pmp_cfg,
    input  logic [prot_pkg::PMP_ENTRIES-1:0][31:0]         pmp_addr,
    output prot_pkg::prot_result_t                         pmp_res
);

    import prot_pkg::*;

    function automatic logic pmp_fault(
        input logic [31:0] addr,
        input logic        need_r,
        input logic        need_w,
        input logic        need_x
    );
        logic [31:0] word;
        logic [31:0] lo;
        logic [31:0] mask;
        logic        hit;
        logic        found;
        logic        fault;

        // pmpaddr holds bits 33:2 of the address
        word  = {2'b00, addr[31:2]};
        lo    = '0;
        found = 1'b0;
        // No matching entry: only M mode passes
        fault = (priv_level != M_MODE);

        for (int i = 0; i < PMP_ENTRIES; i++) begin
            // Trailing ones plus the next bit are don't-care in NAPOT
            mask = ~(pmp_addr[i] ^ (pmp_addr[i] + 32'd1));
            case (pmp_cfg[i].a)
                PMP_TOR: begin
                    hit = (word >= lo) && (word < pmp_addr[i]);
                end
                PMP_NA4: begin
                    hit = (word == pmp_addr[i]);
                end
                PMP_NAPOT: begin
                    hit = ((word & mask) == (pmp_addr[i] & mask));
                end
                default: begin
                    hit = 1'b0;
                end
            endcase

            if (hit && !found) begin
                found = 1'b1;
                if ((priv_level == M_MODE) && !pmp_cfg[i].l) begin
                    // Unlocked entries do not bind M mode
                    fault = 1'b0;
                end else begin
                    fault = (need_r & ~pmp_cfg[i].r) |
                            (need_w & ~pmp_cfg[i].w) |
                            (need_x & ~pmp_cfg[i].x);
                end
            end

            // Bottom of the next TOR range
            lo = pmp_addr[i];
        end
        return fault;
    endfunction

    always_comb begin
        pmp_res.i_fault = ireq.en && pmp_fault(ireq.addr, 1'b0, 1'b0, 1'b1);
        pmp_res.l_fault = dreq.en && !dwen && pmp_fault(dreq.addr, 1'b1, 1'b0, 1'b0);
        pmp_res.s_fault = dreq.en && dwen && pmp_fault(dreq.addr, 1'b0, 1'b1, 1'b0);
    end

    // A store must carry a defined address
    a_store_addr_known: assert final (
        !((dreq.en === 1'b1) && (dwen === 1'b1)) || !$isunknown(dreq.addr)
    ) else $error("store request with unknown address");

endmodule

// File: verilog/pmp_csr.sv
// PMP CSR block
// Holds pmpcfg0 and pmpaddr0..3, applies the lock rules on writes
// and returns the addressed register combinationally
module pmp_csr (
    input  logic                                               CLK,
    input  logic                                               rst_n,
    input  prot_pkg::csr_req_t                                 csr_req,
    output logic [31:0]                                        csr_rdata,
    output prot_pkg::pmp_cfg_t [prot_pkg::PMP_ENTRIES-1:0]     pmp_cfg,
    output logic [prot_pkg::PMP_ENTRIES-1:0][31:0]             pmp_addr
);

    import prot_pkg::*;

    pmp_cfg_t [PMP_ENTRIES-1:0]   cfg_q;
    pmp_cfg_t [PMP_ENTRIES-1:0]   cfg_wr;
    logic [PMP_ENTRIES-1:0][31:0] addr_q;
    logic [PMP_ENTRIES-1:0]       addr_lock;
    logic [11:0]                  addr_off;
    logic                         addr_hit;
    logic [PMP_IDX_W-1:0]         addr_idx;

    // pmpaddr decode
    assign addr_off = csr_req.addr - CSR_PMPADDR0;
    assign addr_hit = addr_off < 12'(PMP_ENTRIES);
    assign addr_idx = addr_off[PMP_IDX_W-1:0];

    // Reserved cfg bits read as zero
    always_comb begin
        for (int i = 0; i < PMP_ENTRIES; i++) begin
            cfg_wr[i]      = pmp_cfg_t'(csr_req.wdata[8*i +: 8]);
            cfg_wr[i].rsvd = 2'b00;
        end
    end

    for (genvar g = 0; g < PMP_ENTRIES; g++) begin : g_entry
        // An address is also frozen when the next entry is a locked TOR top
        if (g < PMP_ENTRIES - 1) begin : g_next
            assign addr_lock[g] = cfg_q[g].l |
                                  (cfg_q[g+1].l & (cfg_q[g+1].a == PMP_TOR));
        end else begin : g_last
            assign addr_lock[g] = cfg_q[g].l;
        end

        a_locked_cfg_stable: assert property (
            @(posedge CLK) disable iff (!rst_n)
            cfg_q[g].l |=> $stable(cfg_q[g])
        ) else $error("pmpcfg entry %0d changed while locked", g);
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q  <= '0;
            addr_q <= '0;
        end else if (csr_req.wen) begin
            if (csr_req.addr == CSR_PMPCFG0) begin
                for (int i = 0; i < PMP_ENTRIES; i++) begin
                    if (!cfg_q[i].l) begin
                        cfg_q[i] <= cfg_wr[i];
                    end
                end
            end
            if (addr_hit && !addr_lock[addr_idx]) begin
                addr_q[addr_idx] <= csr_req.wdata;
            end
        end
    end

    // Read-back, unknown addresses give zero
    always_comb begin
        csr_rdata = '0;
        if (csr_req.addr == CSR_PMPCFG0) begin
            csr_rdata = cfg_q;
        end else if (addr_hit) begin
            csr_rdata = addr_q[addr_idx];
        end
    end

    assign pmp_cfg  = cfg_q;
    assign pmp_addr = addr_q;

endmodule

// File: verilog/prot_fault_unit.sv
// Protection fault unit
// Combines PMA and PMP results per port, registers the fault strobes
// and reports the cause and address of the highest-priority fault
module prot_fault_unit (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  prot_pkg::prot_result_t pma_res,
    input  prot_pkg::prot_result_t pmp_res,
    input  prot_pkg::mem_req_t     ireq,
    input  prot_pkg::mem_req_t     dreq,
    output logic                   prot_fault_i,
    output logic                   prot_fault_l,
    output logic                   prot_fault_s,
    output logic [3:0]             fault_cause,
    output logic [31:0]            fault_addr
);

    import prot_pkg::*;

    prot_result_t flt_d;
    prot_result_t flt_q;
    logic [3:0]   cause_d;
    logic [31:0]  addr_d;

    always_comb begin
        flt_d.i_fault = pma_res.i_fault | pmp_res.i_fault;
        flt_d.l_fault = pma_res.l_fault | pmp_res.l_fault;
        flt_d.s_fault = pma_res.s_fault | pmp_res.s_fault;

        // Instruction first, then load, then store
        cause_d = CAUSE_NONE;
        addr_d  = '0;
        if (flt_d.i_fault) begin
            cause_d = CAUSE_I_ACCESS;
            addr_d  = ireq.addr;
        end else if (flt_d.l_fault) begin
            cause_d = CAUSE_L_ACCESS;
            addr_d  = dreq.addr;
        end else if (flt_d.s_fault) begin
            cause_d = CAUSE_S_ACCESS;
            addr_d  = dreq.addr;
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            flt_q       <= '0;
            fault_cause <= CAUSE_NONE;
            fault_addr  <= '0;
        end else begin
            flt_q       <= flt_d;
            fault_cause <= cause_d;
            fault_addr  <= addr_d;
        end
    end

    assign prot_fault_i = flt_q.i_fault;
    assign prot_fault_l = flt_q.l_fault;
    assign prot_fault_s = flt_q.s_fault;

    a_cause_tracks_strobe: assert property (
        @(posedge CLK) disable iff (!rst_n)
        (fault_cause != CAUSE_NONE) == (prot_fault_i | prot_fault_l | prot_fault_s)
    ) else $error("fault_cause %0d disagrees with fault strobes", fault_cause);

endmodule

// File: verilog/prot_pkg.sv
// Memory protection package
// Shared privilege, request and result types, PMA region table,
// PMP mode codes, CSR addresses and access fault cause codes
package prot_pkg;

    // Privilege levels, S mode left out
    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        M_MODE = 2'b11
    } priv_level_t;

    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10
    } acc_width_t;

    // One port's memory request
    typedef struct packed {
        logic       en;
        logic [31:0] addr;
        acc_width_t width;
    } mem_req_t;

    // Single-cycle CSR access
    typedef struct packed {
        logic        wen;
        logic [11:0] addr;
        logic [31:0] wdata;
    } csr_req_t;

    // Per-port fault flags from one checker
    typedef struct packed {
        logic i_fault;
        logic l_fault;
        logic s_fault;
    } prot_result_t;

    // pmpcfg byte, bit 0 is r
    typedef struct packed {
        logic       l;
        logic [1:0] rsvd;
        logic [1:0] a;
        logic       x;
        logic       w;
        logic       r;
    } pmp_cfg_t;

    typedef struct packed {
        logic r;
        logic w;
        logic x;
        logic word_only;
    } pma_attr_t;

    localparam int PMP_ENTRIES = 4;
    localparam int PMP_IDX_W   = $clog2(PMP_ENTRIES);

    // PMP address matching modes
    localparam logic [1:0] PMP_OFF   = 2'd0;
    localparam logic [1:0] PMP_TOR   = 2'd1;
    localparam logic [1:0] PMP_NA4   = 2'd2;
    localparam logic [1:0] PMP_NAPOT = 2'd3;

    localparam logic [11:0] CSR_PMPCFG0  = 12'h3A0;
    localparam logic [11:0] CSR_PMPADDR0 = 12'h3B0;

    // Fixed PMA regions
    localparam logic [31:0] ROM_BASE = 32'h0000_0000;
    localparam logic [31:0] ROM_SIZE = 32'h0001_0000;
    localparam pma_attr_t   ROM_ATTR = '{r: 1'b1, w: 1'b0, x: 1'b1, word_only: 1'b0};

    localparam logic [31:0] IO_BASE  = 32'h4000_0000;
    localparam logic [31:0] IO_SIZE  = 32'h0000_1000;
    localparam pma_attr_t   IO_ATTR  = '{r: 1'b1, w: 1'b1, x: 1'b0, word_only: 1'b1};

    localparam logic [31:0] RAM_BASE = 32'h8000_0000;
    localparam logic [31:0] RAM_SIZE = 32'h0001_0000;
    localparam pma_attr_t   RAM_ATTR = '{r: 1'b1, w: 1'b1, x: 1'b1, word_only: 1'b0};

    // mcause values for access faults
    localparam logic [3:0] CAUSE_NONE     = 4'd0;
    localparam logic [3:0] CAUSE_I_ACCESS = 4'd1;
    localparam logic [3:0] CAUSE_L_ACCESS = 4'd5;
    localparam logic [3:0] CAUSE_S_ACCESS = 4'd7;

endpackage

// File: verilog/prot_unit.sv
// Memory protection unit
// PMP CSRs, PMA and PMP checkers side by side, and the fault unit
// that reports one registered strobe per port
module prot_unit (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  prot_pkg::priv_level_t priv_level,
    input  prot_pkg::csr_req_t    csr_req,
    input  prot_pkg::mem_req_t    ireq,
    input  prot_pkg::mem_req_t    dreq,
    input  logic                  dwen,
    output logic [31:0]           csr_rdata,
    output logic                  prot_fault_i,
    output logic                  prot_fault_l,
    output logic                  prot_fault_s,
    output logic [3:0]            fault_cause,
    output logic [31:0]           fault_addr
);

    import prot_pkg::*;

    pmp_cfg_t [PMP_ENTRIES-1:0]   pmp_cfg;
    logic [PMP_ENTRIES-1:0][31:0] pmp_addr;
    prot_result_t                 pma_res;
    prot_result_t                 pmp_res;

    pmp_csr u_pmp_csr (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .csr_req   (csr_req),
        .csr_rdata (csr_rdata),
        .pmp_cfg   (pmp_cfg),
        .pmp_addr  (pmp_addr)
    );

    pma_checker u_pma (
        .ireq    (ireq),
        .dreq    (dreq),
        .dwen    (dwen),
        .pma_res (pma_res)
    );

    pmp_checker u_pmp (
        .priv_level (priv_level),
        .ireq       (ireq),
        .dreq       (dreq),
        .dwen       (dwen),
        .pmp_cfg    (pmp_cfg),
        .pmp_addr   (pmp_addr),
        .pmp_res    (pmp_res)
    );

    prot_fault_unit u_fault (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .pma_res      (pma_res),
        .pmp_res      (pmp_res),
        .ireq         (ireq),
        .dreq         (dreq),
        .prot_fault_i (prot_fault_i),
        .prot_fault_l (prot_fault_l),
        .prot_fault_s (prot_fault_s),
        .fault_cause  (fault_cause),
        .fault_addr   (fault_addr)
    );

endmodule
